// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_readout_demod
FILELIST  := readout_demod.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Simulation completed successfully

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/iq_rotator.sv ====
module iq_rotator (
    input  logic                        clk100,
    input  logic                        reset,
    input  readout_data_pkg::sel_beat_t i_beat,
    output readout_data_pkg::rot_beat_t o_beat  // 2 cycles after i_beat
);

    localparam int LANES = readout_data_pkg::NUM_LANES;

    readout_data_pkg::sample_t sin_v [LANES];  // table out
    readout_data_pkg::sample_t cos_v [LANES];
    readout_data_pkg::sample_t i_d1  [LANES];  // samples lined up with table
    readout_data_pkg::sample_t q_d1  [LANES];
    logic [LANES-1:0]          vld_d1;
    logic                      last_d1;
    readout_data_pkg::rot_t    rot_i [LANES];
    readout_data_pkg::rot_t    rot_q [LANES];

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        sincos_rom u_rom (
            .clk100  (clk100),
            .i_phase (i_beat.lane[g].phase),
            .o_sin   (sin_v[g]),
            .o_cos   (cos_v[g])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1, wait for the table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        if (reset) begin
            vld_d1  <= '0;
            last_d1 <= 1'b0;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                vld_d1[l] <= i_beat.lane[l].valid;
            end
            last_d1 <= i_beat.last;
        end
        for (int l = 0; l < LANES; l++) begin
            i_d1[l] <= i_beat.lane[l].i;
            q_d1[l] <= i_beat.lane[l].q;
        end
    end

    // rotate by -phase, dropped lanes give zero
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rot_i[l] = '0;
            rot_q[l] = '0;
            if (vld_d1[l]) begin
                rot_i[l] = i_d1[l] * cos_v[l] + q_d1[l] * sin_v[l];
                rot_q[l] = q_d1[l] * cos_v[l] - i_d1[l] * sin_v[l];
            end
        end
    end

    // stage 2, products
    always_ff @(posedge clk100) begin
        if (reset) begin
            for (int l = 0; l < LANES; l++) begin
                o_beat.lane[l].valid <= 1'b0;
            end
            o_beat.last <= 1'b0;
        end else begin
            for (int l = 0; l < LANES; l++) begin
                o_beat.lane[l].valid <= vld_d1[l];
            end
            o_beat.last <= last_d1;
        end
        for (int l = 0; l < LANES; l++) begin
            o_beat.lane[l].i <= rot_i[l];
            o_beat.lane[l].q <= rot_q[l];
        end
    end

endmodule

// ==== hdl/lane_integrator.sv ====
module lane_integrator (
    input  logic                        clk100,
    input  logic                        reset,
    input  readout_data_pkg::rot_beat_t i_beat,
    output logic                        o_iq_valid,  // one cycle after last beat
    output readout_data_pkg::acc_t      o_i_total,   // held until next pulse
    output readout_data_pkg::acc_t      o_q_total
);

    localparam int LANES = readout_data_pkg::NUM_LANES;

    readout_data_pkg::acc_t acc_i;  // running window sums
    readout_data_pkg::acc_t acc_q;
    readout_data_pkg::acc_t sum_i;  // this beat, all lanes
    readout_data_pkg::acc_t sum_q;

    // lane sum, sign extended to accumulator width
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int l = 0; l < LANES; l++) begin
            if (i_beat.lane[l].valid) begin
                sum_i = sum_i + readout_data_pkg::acc_t'(i_beat.lane[l].i);
                sum_q = sum_q + readout_data_pkg::acc_t'(i_beat.lane[l].q);
            end
        end
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            acc_i      <= '0;
            acc_q      <= '0;
            o_iq_valid <= 1'b0;
            o_i_total  <= '0;
            o_q_total  <= '0;
        end else begin
            o_iq_valid <= i_beat.last;
            if (i_beat.last) begin
                o_i_total <= acc_i + sum_i;  // includes the last beat
                o_q_total <= acc_q + sum_q;
                acc_i     <= '0;             // ready for next window
                acc_q     <= '0;
            end else begin
                acc_i <= acc_i + sum_i;
                acc_q <= acc_q + sum_q;
            end
        end
    end

endmodule

// ==== hdl/readout_cfg_pkg.sv ====
package readout_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // readout settings, one field per knob
    //////////////////////////////////////////////////////////////////////

    typedef logic [4:0]  demod_freq_t;  // units of 10 MHz
    typedef logic [5:0]  skip_t;        // stride in samples, 1 = keep all
    typedef logic [10:0] length_t;      // window, clk100 cycles
    typedef logic [13:0] delay_t;       // trigger to window, clk100 cycles

    typedef struct packed {
        demod_freq_t freq;
        skip_t       skip;
        length_t     length;
        delay_t      delay;
    } readout_cfg_t;

    // power-up settings
    localparam readout_cfg_t CFG_DEFAULT = '{
        freq:   5'd5,      // 50 MHz
        skip:   6'd5,      // one sample per cycle
        length: 11'd2000,  // 20 us
        delay:  14'd5000   // 50 us
    };

endpackage

// ==== hdl/readout_cfg_regs.sv ====
module readout_cfg_regs (
    input  logic                          clk100,
    input  logic                          reset,
    input  logic                          i_cfg_load,  // strobe, idle only
    input  readout_cfg_pkg::readout_cfg_t i_cfg_new,
    output readout_cfg_pkg::readout_cfg_t o_cfg
);

    // active settings, held between loads
    always_ff @(posedge clk100) begin
        if (reset) begin
            o_cfg <= readout_cfg_pkg::CFG_DEFAULT;  // back to defaults
        end else if (i_cfg_load) begin
            o_cfg <= i_cfg_new;  // whole word at once
        end
    end

endmodule

// ==== hdl/readout_data_pkg.sv ====
package readout_data_pkg;

    localparam int NUM_LANES = 5;   // adc samples per clk100
    localparam int PHASE_MOD = 50;  // 500 MHz adc over 10 MHz freq unit

    typedef logic [5:0]         phase_t;   // 0 .. PHASE_MOD-1
    typedef logic signed [15:0] sample_t;  // raw adc word, also table word
    typedef logic signed [31:0] rot_t;     // rotated sample
    typedef logic signed [47:0] acc_t;     // window sum

    // adc input, lane 0 is the oldest sample of the cycle
    typedef struct packed {
        sample_t [NUM_LANES-1:0] i;
        sample_t [NUM_LANES-1:0] q;
    } lane_in_t;

    //////////////////////////////////////////////////////////////////////
    // beats between pipeline stages
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic    valid;  // sample kept by the stride
        phase_t  phase;  // 0 when not kept
        sample_t i;
        sample_t q;
    } sel_lane_t;

    typedef struct packed {
        sel_lane_t [NUM_LANES-1:0] lane;
        logic                      last;  // final window cycle
    } sel_beat_t;

    typedef struct packed {
        logic valid;
        rot_t i;
        rot_t q;
    } rot_lane_t;

    typedef struct packed {
        rot_lane_t [NUM_LANES-1:0] lane;
        logic                      last;
    } rot_beat_t;

endpackage

// ==== hdl/readout_demod_top.sv ====
module readout_demod_top (
    input  logic                          clk100,
    input  logic                          reset,
    input  logic                          i_cfg_load,
    input  readout_cfg_pkg::readout_cfg_t i_cfg_new,
    input  logic                          i_trigger,
    input  readout_data_pkg::lane_in_t    i_lanes,
    output logic                          o_iq_valid,
    output readout_data_pkg::acc_t        o_i_total,
    output readout_data_pkg::acc_t        o_q_total
);

    readout_cfg_pkg::readout_cfg_t cfg;
    logic                          window_start;
    readout_data_pkg::sel_beat_t   sel_beat;  // window cycle + 1
    readout_data_pkg::rot_beat_t   rot_beat;  // window cycle + 3

    //////////////////////////////////////////////////////////////////////
    // trigger -> delay -> select -> rotate -> integrate
    //////////////////////////////////////////////////////////////////////

    readout_cfg_regs u_cfg_regs (
        .clk100     (clk100),
        .reset      (reset),
        .i_cfg_load (i_cfg_load),
        .i_cfg_new  (i_cfg_new),
        .o_cfg      (cfg)
    );

    trigger_delay u_trigger_delay (
        .clk100         (clk100),
        .reset          (reset),
        .i_trigger      (i_trigger),
        .i_delay        (cfg.delay),
        .o_window_start (window_start)
    );

    sample_selector u_sample_selector (
        .clk100  (clk100),
        .reset   (reset),
        .i_start (window_start),
        .i_lanes (i_lanes),
        .i_cfg   (cfg),
        .o_beat  (sel_beat)
    );

    iq_rotator u_iq_rotator (
        .clk100 (clk100),
        .reset  (reset),
        .i_beat (sel_beat),
        .o_beat (rot_beat)
    );

    lane_integrator u_lane_integrator (
        .clk100     (clk100),
        .reset      (reset),
        .i_beat     (rot_beat),
        .o_iq_valid (o_iq_valid),
        .o_i_total  (o_i_total),
        .o_q_total  (o_q_total)
    );

endmodule

// ==== hdl/sample_selector.sv ====
module sample_selector (
    input  logic                          clk100,
    input  logic                          reset,
    input  logic                          i_start,  // first window cycle
    input  readout_data_pkg::lane_in_t    i_lanes,
    input  readout_cfg_pkg::readout_cfg_t i_cfg,
    output readout_data_pkg::sel_beat_t   o_beat
);

    localparam int LANES = readout_data_pkg::NUM_LANES;

    // window state
    logic                     in_window;
    readout_cfg_pkg::length_t cyc_cnt;     // window cycle index
    readout_data_pkg::phase_t base_phase;  // phase of lane 0 this cycle
    readout_cfg_pkg::skip_t   skip_left;   // samples to drop before next keep

    // current cycle view
    logic                     active;
    logic                     last_cyc;
    readout_cfg_pkg::length_t cyc;
    readout_cfg_pkg::skip_t   skip_m1;
    readout_data_pkg::phase_t next_base;
    readout_cfg_pkg::skip_t   next_left;
    logic [LANES-1:0]         keep;
    readout_data_pkg::phase_t lane_phase [LANES];

    // one sample step, freq is always below the modulus
    function automatic readout_data_pkg::phase_t phase_add(
        input readout_data_pkg::phase_t     p,
        input readout_cfg_pkg::demod_freq_t f
    );
        logic [6:0] s;
        s = {1'b0, p} + {2'b00, f};
        if (s >= 7'(readout_data_pkg::PHASE_MOD)) begin
            s = s - 7'(readout_data_pkg::PHASE_MOD);  // wrap
        end
        return s[5:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // lane chain, stride countdown and phase walk across the 5 samples
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        readout_data_pkg::phase_t ph;
        readout_cfg_pkg::skip_t   left;
        active  = in_window | i_start;  // start cycle is window cycle 0
        cyc     = in_window ? cyc_cnt : '0;
        ph      = in_window ? base_phase : '0;
        left    = in_window ? skip_left : '0;
        skip_m1 = (i_cfg.skip == '0) ? '0 : i_cfg.skip - 6'd1;  // skip 0 acts as 1
        for (int l = 0; l < LANES; l++) begin
            keep[l]       = active && (left == '0);
            lane_phase[l] = keep[l] ? ph : '0;
            left          = (left == '0) ? skip_m1 : left - 6'd1;
            ph            = phase_add(ph, i_cfg.freq);
        end
        next_base = ph;    // base + 5*freq mod 50
        next_left = left;  // stride carry into next cycle
        last_cyc  = active && (cyc == i_cfg.length - 11'd1);
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            in_window  <= 1'b0;
            cyc_cnt    <= '0;
            base_phase <= '0;
            skip_left  <= '0;
            for (int l = 0; l < LANES; l++) begin
                o_beat.lane[l].valid <= 1'b0;
            end
            o_beat.last <= 1'b0;
        end else begin
            if (active) begin
                in_window  <= !last_cyc;  // starts inside a window are ignored
                cyc_cnt    <= cyc + 11'd1;
                base_phase <= next_base;
                skip_left  <= next_left;
            end
            for (int l = 0; l < LANES; l++) begin
                o_beat.lane[l].valid <= keep[l];
            end
            o_beat.last <= last_cyc;
        end
        // samples ride along with their phase
        for (int l = 0; l < LANES; l++) begin
            o_beat.lane[l].phase <= lane_phase[l];
            o_beat.lane[l].i     <= i_lanes.i[l];
            o_beat.lane[l].q     <= i_lanes.q[l];
        end
    end

endmodule

// ==== hdl/sincos_rom.sv ====
module sincos_rom (
    input  logic                      clk100,
    input  readout_data_pkg::phase_t  i_phase,
    output readout_data_pkg::sample_t o_sin,  // one cycle after i_phase
    output readout_data_pkg::sample_t o_cos
);

    //////////////////////////////////////////////////////////////////////
    // round(16383 * sin(2*pi*k/50)), cos column is the quarter turn shift
    //////////////////////////////////////////////////////////////////////

    localparam readout_data_pkg::sample_t SIN_TAB [readout_data_pkg::PHASE_MOD] = '{
        16'sd0,      16'sd2053,   16'sd4074,   16'sd6031,   16'sd7893,   16'sd9630,
        16'sd11215,  16'sd12623,  16'sd13833,  16'sd14824,  16'sd15581,  16'sd16093,
        16'sd16351,  16'sd16351,  16'sd16093,  16'sd15581,  16'sd14824,  16'sd13833,
        16'sd12623,  16'sd11215,  16'sd9630,   16'sd7893,   16'sd6031,   16'sd4074,
        16'sd2053,   16'sd0,      -16'sd2053,  -16'sd4074,  -16'sd6031,  -16'sd7893,
        -16'sd9630,  -16'sd11215, -16'sd12623, -16'sd13833, -16'sd14824, -16'sd15581,
        -16'sd16093, -16'sd16351, -16'sd16351, -16'sd16093, -16'sd15581, -16'sd14824,
        -16'sd13833, -16'sd12623, -16'sd11215, -16'sd9630,  -16'sd7893,  -16'sd6031,
        -16'sd4074,  -16'sd2053
    };

    // half-step sine values, so kept as its own column
    localparam readout_data_pkg::sample_t COS_TAB [readout_data_pkg::PHASE_MOD] = '{
        16'sd16383,  16'sd16254,  16'sd15868,  16'sd15233,  16'sd14357,  16'sd13254,
        16'sd11943,  16'sd10443,  16'sd8778,   16'sd6976,   16'sd5063,   16'sd3070,
        16'sd1029,   -16'sd1029,  -16'sd3070,  -16'sd5063,  -16'sd6976,  -16'sd8778,
        -16'sd10443, -16'sd11943, -16'sd13254, -16'sd14357, -16'sd15233, -16'sd15868,
        -16'sd16254, -16'sd16383, -16'sd16254, -16'sd15868, -16'sd15233, -16'sd14357,
        -16'sd13254, -16'sd11943, -16'sd10443, -16'sd8778,  -16'sd6976,  -16'sd5063,
        -16'sd3070,  -16'sd1029,  16'sd1029,   16'sd3070,   16'sd5063,   16'sd6976,
        16'sd8778,   16'sd10443,  16'sd11943,  16'sd13254,  16'sd14357,  16'sd15233,
        16'sd15868,  16'sd16254
    };

    always_ff @(posedge clk100) begin
        if (i_phase < 6'(readout_data_pkg::PHASE_MOD)) begin
            o_sin <= SIN_TAB[i_phase];
            o_cos <= COS_TAB[i_phase];
        end else begin
            o_sin <= '0;  // out of range phase, no output
            o_cos <= '0;
        end
    end

endmodule

// ==== hdl/trigger_delay.sv ====
module trigger_delay (
    input  logic                    clk100,
    input  logic                    reset,
    input  logic                    i_trigger,
    input  readout_cfg_pkg::delay_t i_delay,
    output logic                    o_window_start  // one cycle, delay after trigger
);

    typedef enum logic {
        IDLE,
        COUNT
    } state_t;

    state_t                  state;
    readout_cfg_pkg::delay_t cnt;  // cycles left until the start pulse

    always_ff @(posedge clk100) begin
        if (reset) begin
            state          <= IDLE;
            cnt            <= '0;
            o_window_start <= 1'b0;
        end else begin
            o_window_start <= 1'b0;  // pulse by default low
            case (state)
                IDLE: begin
                    if (i_trigger) begin
                        if (i_delay <= 14'd1) begin
                            o_window_start <= 1'b1;  // shortest delay, start next cycle
                        end else begin
                            cnt   <= i_delay - 14'd1;
                            state <= COUNT;
                        end
                    end
                end
                COUNT: begin  // triggers ignored while counting
                    if (cnt == 14'd1) begin
                        o_window_start <= 1'b1;
                        state          <= IDLE;
                    end else begin
                        cnt <= cnt - 14'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== readout_demod.f ====
hdl/readout_cfg_pkg.sv
hdl/readout_data_pkg.sv
hdl/readout_cfg_regs.sv
hdl/trigger_delay.sv
hdl/sample_selector.sv
hdl/sincos_rom.sv
hdl/iq_rotator.sv
hdl/lane_integrator.sv
hdl/readout_demod_top.sv
tests/readout_demod_props.sv
tests/tb_readout_demod.sv

// ==== tests/readout_demod_props.sv ====
module readout_demod_props (
    input logic                   clk100,
    input logic                   reset,
    input logic                   o_iq_valid,
    input readout_data_pkg::acc_t o_i_total,
    input readout_data_pkg::acc_t o_q_total
);

    // one pulse per window, never two in a row
    a_single_pulse: assert property (@(posedge clk100) disable iff (reset)
        o_iq_valid |=> !o_iq_valid)
        else $error("result valid high for two cycles in a row");

    // totals move only together with the pulse
    a_hold_i: assert property (@(posedge clk100) disable iff (reset)
        !o_iq_valid |-> $stable(o_i_total))
        else $error("i total changed between result pulses");

    a_hold_q: assert property (@(posedge clk100) disable iff (reset)
        !o_iq_valid |-> $stable(o_q_total))
        else $error("q total changed between result pulses");

endmodule

bind lane_integrator readout_demod_props u_props (
    .clk100     (clk100),
    .reset      (reset),
    .o_iq_valid (o_iq_valid),
    .o_i_total  (o_i_total),
    .o_q_total  (o_q_total)
);

// ==== tests/readout_stimulus.txt ====
# name load retrig freq skip length delay i0 i1 i2 i3 i4 q0 q1 q2 q3 q4 exp_i exp_q
# lane data is constant over the window, exp_i and exp_q are the lane-summed window totals
default    0 0 5 5 2000 5000  100   7  -3  11  42  -50  9  8 -6  1        0         0
cfg_delay  1 0 5 5    3   37  100   7  -3  11  42  -50  9  8 -6  1  1638300   -819150
skip1      1 0 0 1    4   12   10  10  10  10  10    3  3  3  3  3  3276600    982980
skip2      1 0 0 2    5   12   10  10  10  10  10    3  3  3  3  3  2129790    638937
skip3      1 0 0 3    7   12  -20 -20 -20 -20 -20    9  9  9  9  9 -3931920   1769364
skip7      1 0 0 7   10   12    5   5   5   5   5   -4 -4 -4 -4 -4   655320   -524256
skip7_f5   1 0 5 7   10   15    5   5   5   5   5    0  0  0  0  0    91585     29755
freq5      1 0 5 1    3    9  100 200 300 400 500    0  0  0  0  0 -2844200 -17647700
freq3      1 0 3 1    2    9  100 200 300 400 500    0  0  0  0  0 -9764900 -23910600
retrigger  1 1 0 1    2   20    1   2   3   4   5    0  0  0  0  0   491490         0

// ==== tests/tb_readout_demod.sv ====
module tb_readout_demod;

    localparam int LANES     = readout_data_pkg::NUM_LANES;
    localparam int DRIVE_DLY = 5;  // input skew after the rising edge

    // dut ports
    logic                          clk100;
    logic                          reset;
    logic                          i_cfg_load;
    readout_cfg_pkg::readout_cfg_t i_cfg_new;
    logic                          i_trigger;
    readout_data_pkg::lane_in_t    i_lanes;
    logic                          o_iq_valid;
    readout_data_pkg::acc_t        o_i_total;
    readout_data_pkg::acc_t        o_q_total;

    // fields of one stimulus line
    logic [8*24-1:0] name_raw;
    string           tname;
    int              load_flag;    // 0 keeps the current settings
    int              retrig_flag;  // 1 adds a trigger inside the delay
    int              st_freq;
    int              st_skip;
    int              st_length;
    int              st_delay;
    int              lane_i [LANES];
    int              lane_q [LANES];
    longint          exp_i;
    longint          exp_q;

    integer seed;       // idle gap source
    int     cyc_count;  // rising edges since time zero
    int     num_tests;

    readout_demod_top u_dut (
        .clk100     (clk100),
        .reset      (reset),
        .i_cfg_load (i_cfg_load),
        .i_cfg_new  (i_cfg_new),
        .i_trigger  (i_trigger),
        .i_lanes    (i_lanes),
        .o_iq_valid (o_iq_valid),
        .o_i_total  (o_i_total),
        .o_q_total  (o_q_total)
    );

    initial clk100 = 1'b0;
    always #50 clk100 = ~clk100;  // period 100

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic step_cycle();
        @(posedge clk100);
        #DRIVE_DLY;  // drive and sample clear of the edge
        cyc_count++;
    endtask

    task automatic stop_on_error(input string why);
        $display("%0s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string what, input longint expected, input longint actual);
        assert (actual == expected) else begin
            stop_on_error($sformatf("FAILED %0s %0s: expected %0d, actual %0d",
                                    tname, what, expected, actual));
        end
    endtask

    task automatic wait_for_result(input int limit);
        int waited;
        waited = 0;
        while (o_iq_valid !== 1'b1) begin
            if (waited >= limit) begin
                stop_on_error($sformatf("timeout in %0s, no result pulse within %0d cycles",
                                        tname, limit));
            end
            step_cycle();
            waited++;
        end
    endtask

    // a stray second trigger would show up here
    task automatic expect_no_result(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            step_cycle();
            assert (o_iq_valid == 1'b0) else begin
                stop_on_error($sformatf("extra result pulse in %0s, %0d cycles after the first",
                                        tname, k + 1));
            end
        end
    endtask

    task automatic apply_test();
        int t0;
        int lat_exp;
        tname   = $sformatf("%0s", name_raw);
        lat_exp = st_delay + st_length + 3;  // trigger cycle to valid cycle
        for (int l = 0; l < LANES; l++) begin
            i_lanes.i[l] = 16'(lane_i[l]);  // held for the whole test
            i_lanes.q[l] = 16'(lane_q[l]);
        end
        if (load_flag != 0) begin
            i_cfg_new.freq   = 5'(st_freq);
            i_cfg_new.skip   = 6'(st_skip);
            i_cfg_new.length = 11'(st_length);
            i_cfg_new.delay  = 14'(st_delay);
            i_cfg_load       = 1'b1;
            step_cycle();
            i_cfg_load = 1'b0;
            step_cycle();
        end
        i_trigger = 1'b1;
        t0        = cyc_count;
        step_cycle();
        i_trigger = 1'b0;
        if (retrig_flag != 0) begin
            repeat (2) step_cycle();
            i_trigger = 1'b1;  // lands inside the delay count
            step_cycle();
            i_trigger = 1'b0;
        end
        wait_for_result(lat_exp + 50);
        check_value("latency", longint'(lat_exp), longint'(cyc_count - t0));
        check_value("i_total", exp_i, longint'(o_i_total));
        check_value("q_total", exp_q, longint'(o_q_total));
        if (retrig_flag != 0) begin
            expect_no_result(lat_exp + 10);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    nread;
        int    gap;
        string line;
        seed       = 14;
        cyc_count  = 0;
        num_tests  = 0;
        reset      = 1'b1;
        i_cfg_load = 1'b0;
        i_cfg_new  = readout_cfg_pkg::CFG_DEFAULT;
        i_trigger  = 1'b0;
        i_lanes    = '0;
        repeat (10) step_cycle();
        reset = 1'b0;
        step_cycle();
        assert (o_iq_valid == 1'b0 && u_dut.u_trigger_delay.o_window_start == 1'b0) else begin
            stop_on_error("result or window start pulse high right after reset");
        end
        fd = $fopen("tests/readout_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open tests/readout_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;  // header or blank
            end
            nread = $sscanf(line,
                "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                name_raw, load_flag, retrig_flag, st_freq, st_skip, st_length, st_delay,
                lane_i[0], lane_i[1], lane_i[2], lane_i[3], lane_i[4],
                lane_q[0], lane_q[1], lane_q[2], lane_q[3], lane_q[4], exp_i, exp_q);
            if (nread != 19) begin
                stop_on_error($sformatf("stimulus line with %0d fields instead of 19", nread));
            end
            apply_test();
            num_tests++;
            gap = 2 + int'($unsigned($random(seed)) % 32'd8);  // idle between tests
            repeat (gap) step_cycle();
        end
        $fclose(fd);
        if (num_tests > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("stimulus file held no tests");
        end
    end

endmodule
